// ==== hdl/commit_defines.svh ====
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// datapath widths
`define COMMIT_DATA_W 32
`define COMMIT_REG_W 5

// every exception redirects here
`define COMMIT_EXC_VECTOR 32'hbfc0_0380

// cause codes as seen in the cause register
`define COMMIT_CAUSE_INT 5'd0
`define COMMIT_CAUSE_ADEL 5'd4
`define COMMIT_CAUSE_ADES 5'd5
`define COMMIT_CAUSE_SYS 5'd8

// lane operation kinds
`define COMMIT_OP_ALU 2'd0
`define COMMIT_OP_LOAD 2'd1
`define COMMIT_OP_STORE 2'd2
`define COMMIT_OP_SYSCALL 2'd3

`endif

// ==== hdl/commit_pkg.sv ====
`include "commit_defines.svh"

package commit_pkg;

    // data word and address
    typedef logic [`COMMIT_DATA_W-1:0] word_t;

    // destination register number
    typedef logic [`COMMIT_REG_W-1:0] reg_addr_t;

    // exception cause code
    typedef logic [4:0] cause_t;

    // lane operation kind, see COMMIT_OP_* in the defines
    typedef logic [1:0] op_kind_t;

    // lane index inside a bundle
    typedef logic lane_t;

    // exception stage
    typedef enum logic [1:0]
    {
        ex_idle,
        ex_hold,
        ex_mem_wait,
        ex_blocked
    } ex_state_t;

    // data stage
    typedef enum logic [1:0]
    {
        dt_empty,
        dt_wait_data,
        dt_done
    } dt_state_t;

endpackage

// ==== hdl/commit_if.sv ====
`timescale 1ns/1ps

interface commit_if;

    // handshake between the two stages
    logic                          full;
    logic                          advance;

    // per lane bundle fields
    logic                    [1:0] valid;
    commit_pkg::op_kind_t    [1:0] kind;
    commit_pkg::word_t       [1:0] pc;
    commit_pkg::reg_addr_t   [1:0] dest;
    commit_pkg::word_t       [1:0] result;

    // exception result of the bundle
    logic                          exc_valid;
    commit_pkg::lane_t             exc_lane;
    commit_pkg::cause_t            exc_cause;
    commit_pkg::word_t             exc_epc;
    logic                          is_load;

    modport producer
    (
        output full, valid, kind, pc, dest, result,
        output exc_valid, exc_lane, exc_cause, exc_epc, is_load,
        input  advance
    );

    modport consumer
    (
        input  full, valid, kind, pc, dest, result,
        input  exc_valid, exc_lane, exc_cause, exc_epc, is_load,
        output advance
    );

endinterface

// ==== hdl/exception_stage.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module exception_stage
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  lane0_valid,
    input  commit_pkg::op_kind_t  lane0_kind,
    input  commit_pkg::word_t     lane0_pc,
    input  commit_pkg::reg_addr_t lane0_dest,
    input  commit_pkg::word_t     lane0_addr,
    input  commit_pkg::word_t     lane0_wdata,
    input  commit_pkg::word_t     lane0_result,
    input  logic                  lane1_valid,
    input  commit_pkg::op_kind_t  lane1_kind,
    input  commit_pkg::word_t     lane1_pc,
    input  commit_pkg::reg_addr_t lane1_dest,
    input  commit_pkg::word_t     lane1_addr,
    input  commit_pkg::word_t     lane1_wdata,
    input  commit_pkg::word_t     lane1_result,
    input  logic                  irq,
    input  logic                  status_ie,
    input  logic                  unblock,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output commit_pkg::word_t     dmem_addr,
    output commit_pkg::word_t     dmem_wdata,
    input  logic                  dmem_addr_ok,
    commit_if.producer            cx
);

    // only lane 0 is wired to the data port
    localparam int MEM_LANE = 0;

    logic                    [1:0] in_lv;
    commit_pkg::op_kind_t    [1:0] in_kind;
    commit_pkg::word_t       [1:0] in_pc;
    commit_pkg::reg_addr_t   [1:0] in_dest;
    commit_pkg::word_t       [1:0] in_addr;
    commit_pkg::word_t       [1:0] in_wdata;
    commit_pkg::word_t       [1:0] in_result;
    logic                    [1:0] lane_fault;
    commit_pkg::cause_t      [1:0] lane_cause;
    logic                          int_taken;
    logic                          exc_hit;
    commit_pkg::lane_t             exc_lane_n;
    commit_pkg::cause_t            exc_cause_n;
    commit_pkg::word_t             exc_epc_n;
    logic                          mem_go;
    logic                          accept;
    logic                          pass;
    logic                          mem_we;
    commit_pkg::word_t             mem_addr;
    commit_pkg::word_t             mem_wdata;
    commit_pkg::ex_state_t         state;

    function automatic logic is_mem(input commit_pkg::op_kind_t k);
        return (k == `COMMIT_OP_LOAD) || (k == `COMMIT_OP_STORE);
    endfunction

    assign in_lv     = {lane1_valid, lane0_valid};
    assign in_kind   = {lane1_kind, lane0_kind};
    assign in_pc     = {lane1_pc, lane0_pc};
    assign in_dest   = {lane1_dest, lane0_dest};
    assign in_addr   = {lane1_addr, lane0_addr};
    assign in_wdata  = {lane1_wdata, lane0_wdata};
    assign in_result = {lane1_result, lane0_result};

    // per lane alignment and syscall check
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            lane_fault[i] = 1'b0;
            lane_cause[i] = `COMMIT_CAUSE_SYS;
            if (in_lv[i])
            begin
                case (in_kind[i])
                    `COMMIT_OP_LOAD:
                    begin
                        lane_fault[i] = |in_addr[i][1:0];
                        lane_cause[i] = `COMMIT_CAUSE_ADEL;
                    end
                    `COMMIT_OP_STORE:
                    begin
                        lane_fault[i] = |in_addr[i][1:0];
                        lane_cause[i] = `COMMIT_CAUSE_ADES;
                    end
                    `COMMIT_OP_SYSCALL:
                        lane_fault[i] = 1'b1;
                    default:
                        lane_fault[i] = 1'b0;
                endcase
            end
        end
    end

    assign int_taken = irq && status_ie;

    // interrupt first, then lane 0, then lane 1
    always_comb
    begin
        exc_hit     = 1'b1;
        exc_lane_n  = 1'b0;
        exc_cause_n = `COMMIT_CAUSE_INT;
        exc_epc_n   = lane0_pc;
        if (int_taken)
            exc_cause_n = `COMMIT_CAUSE_INT;
        else if (lane_fault[0])
            exc_cause_n = lane_cause[0];
        else if (lane_fault[1])
        begin
            exc_lane_n  = 1'b1;
            exc_cause_n = lane_cause[1];
            exc_epc_n   = lane1_pc;
        end
        else
            exc_hit = 1'b0;
    end

    assign mem_go = in_lv[MEM_LANE] && is_mem(in_kind[MEM_LANE]) &&
                    !int_taken && !lane_fault[MEM_LANE];

    // request only while the data stage can take the bundle on addr_ok
    assign dmem_req   = (state == commit_pkg::ex_mem_wait) && cx.advance;
    assign dmem_we    = mem_we;
    assign dmem_addr  = mem_addr;
    assign dmem_wdata = mem_wdata;

    assign cx.full = (state == commit_pkg::ex_hold) || (dmem_req && dmem_addr_ok);
    assign pass    = cx.full && cx.advance;

    assign in_ready = (state == commit_pkg::ex_idle) ||
                      (state == commit_pkg::ex_blocked && unblock) ||
                      (pass && !cx.exc_valid);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= commit_pkg::ex_idle;
        else if (accept)
            state <= mem_go ? commit_pkg::ex_mem_wait : commit_pkg::ex_hold;
        else if (pass)
            state <= cx.exc_valid ? commit_pkg::ex_blocked : commit_pkg::ex_idle;
        else if (state == commit_pkg::ex_blocked && unblock)
            state <= commit_pkg::ex_idle;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cx.valid     <= in_lv;
            cx.kind      <= in_kind;
            cx.pc        <= in_pc;
            cx.dest      <= in_dest;
            cx.result    <= in_result;
            cx.exc_valid <= exc_hit;
            cx.exc_lane  <= exc_lane_n;
            cx.exc_cause <= exc_cause_n;
            cx.exc_epc   <= exc_epc_n;
            cx.is_load   <= mem_go && (in_kind[MEM_LANE] == `COMMIT_OP_LOAD);
            mem_we       <= (in_kind[MEM_LANE] == `COMMIT_OP_STORE);
            mem_addr     <= in_addr[MEM_LANE];
            mem_wdata    <= in_wdata[MEM_LANE];
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        dmem_req && !dmem_addr_ok |=> dmem_req && $stable(dmem_we) &&
                                      $stable(dmem_addr) && $stable(dmem_wdata));

    a_lane1_no_mem: assert property (@(posedge clk) disable iff (reset)
        accept && lane1_valid |-> !is_mem(lane1_kind));

endmodule

// ==== hdl/data_stage.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module data_stage
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dmem_data_ok,
    input  commit_pkg::word_t     dmem_rdata,
    commit_if.consumer            cx,
    output logic                  unblock,
    output logic                  lane0_wb_valid,
    output commit_pkg::word_t     lane0_wb_pc,
    output commit_pkg::reg_addr_t lane0_wb_dest,
    output commit_pkg::word_t     lane0_wb_data,
    output logic                  lane1_wb_valid,
    output commit_pkg::word_t     lane1_wb_pc,
    output commit_pkg::reg_addr_t lane1_wb_dest,
    output commit_pkg::word_t     lane1_wb_data,
    output logic                  redirect_valid,
    output commit_pkg::word_t     redirect_pc,
    output commit_pkg::cause_t    exc_cause,
    output commit_pkg::word_t     exc_epc
);

    logic                    [1:0] d_valid;
    commit_pkg::op_kind_t    [1:0] d_kind;
    commit_pkg::word_t       [1:0] d_pc;
    commit_pkg::reg_addr_t   [1:0] d_dest;
    commit_pkg::word_t       [1:0] d_result;
    logic                          d_exc_valid;
    commit_pkg::lane_t             d_exc_lane;
    commit_pkg::cause_t            d_cause;
    commit_pkg::word_t             d_epc;
    commit_pkg::word_t             load_data;
    logic                    [1:0] wb_valid;
    commit_pkg::word_t       [1:0] wb_data;
    logic                          take;
    commit_pkg::dt_state_t         state;

    // a bundle in done leaves on this edge, so it can be replaced
    assign cx.advance = (state == commit_pkg::dt_empty) || (state == commit_pkg::dt_done);
    assign take       = cx.full && cx.advance;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= commit_pkg::dt_empty;
        else if (take)
            state <= cx.is_load ? commit_pkg::dt_wait_data : commit_pkg::dt_done;
        else if (state == commit_pkg::dt_wait_data && dmem_data_ok)
            state <= commit_pkg::dt_done;
        else if (state == commit_pkg::dt_done)
            state <= commit_pkg::dt_empty;
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            d_valid     <= cx.valid;
            d_kind      <= cx.kind;
            d_pc        <= cx.pc;
            d_dest      <= cx.dest;
            d_result    <= cx.result;
            d_exc_valid <= cx.exc_valid;
            d_exc_lane  <= cx.exc_lane;
            d_cause     <= cx.exc_cause;
            d_epc       <= cx.exc_epc;
        end
        if (state == commit_pkg::dt_wait_data && dmem_data_ok)
            load_data <= dmem_rdata;
    end

    // lane 1 dies on any fault, lane 0 only on its own
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            wb_valid[i] = (state == commit_pkg::dt_done) && d_valid[i] &&
                          (d_kind[i] == `COMMIT_OP_ALU || d_kind[i] == `COMMIT_OP_LOAD) &&
                          !(d_exc_valid && (i == 1 || d_exc_lane == 1'b0));
            wb_data[i]  = (d_kind[i] == `COMMIT_OP_LOAD) ? load_data : d_result[i];
        end
    end

    assign lane0_wb_valid = wb_valid[0];
    assign lane0_wb_pc    = d_pc[0];
    assign lane0_wb_dest  = d_dest[0];
    assign lane0_wb_data  = wb_data[0];
    assign lane1_wb_valid = wb_valid[1];
    assign lane1_wb_pc    = d_pc[1];
    assign lane1_wb_dest  = d_dest[1];
    assign lane1_wb_data  = wb_data[1];

    assign redirect_valid = (state == commit_pkg::dt_done) && d_exc_valid;
    assign redirect_pc    = `COMMIT_EXC_VECTOR;
    assign exc_cause      = d_cause;
    assign exc_epc        = d_epc;
    assign unblock        = redirect_valid;

    // lane 0 writes beside a redirect only when lane 1 raised it
    a_no_killed_wb: assert property (@(posedge clk) disable iff (reset)
        redirect_valid && wb_valid[0] |-> d_epc == d_pc[1] && d_cause == `COMMIT_CAUSE_SYS);

    a_data_ok_expected: assert property (@(posedge clk) disable iff (reset)
        dmem_data_ok |-> state == commit_pkg::dt_wait_data);

endmodule

// ==== hdl/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  lane0_valid,
    input  commit_pkg::op_kind_t  lane0_kind,
    input  commit_pkg::word_t     lane0_pc,
    input  commit_pkg::reg_addr_t lane0_dest,
    input  commit_pkg::word_t     lane0_addr,
    input  commit_pkg::word_t     lane0_wdata,
    input  commit_pkg::word_t     lane0_result,
    input  logic                  lane1_valid,
    input  commit_pkg::op_kind_t  lane1_kind,
    input  commit_pkg::word_t     lane1_pc,
    input  commit_pkg::reg_addr_t lane1_dest,
    input  commit_pkg::word_t     lane1_addr,
    input  commit_pkg::word_t     lane1_wdata,
    input  commit_pkg::word_t     lane1_result,
    input  logic                  irq,
    input  logic                  status_ie,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output commit_pkg::word_t     dmem_addr,
    output commit_pkg::word_t     dmem_wdata,
    input  logic                  dmem_addr_ok,
    input  logic                  dmem_data_ok,
    input  commit_pkg::word_t     dmem_rdata,
    output logic                  lane0_wb_valid,
    output commit_pkg::word_t     lane0_wb_pc,
    output commit_pkg::reg_addr_t lane0_wb_dest,
    output commit_pkg::word_t     lane0_wb_data,
    output logic                  lane1_wb_valid,
    output commit_pkg::word_t     lane1_wb_pc,
    output commit_pkg::reg_addr_t lane1_wb_dest,
    output commit_pkg::word_t     lane1_wb_data,
    output logic                  redirect_valid,
    output commit_pkg::word_t     redirect_pc,
    output commit_pkg::cause_t    exc_cause,
    output commit_pkg::word_t     exc_epc
);

    // redirect seen, exception stage may take bundles again
    logic unblock;

    commit_if u_commit_if ();

    exception_stage u_exception_stage
    (
        .clk, .reset, .in_valid, .in_ready,
        .lane0_valid, .lane0_kind, .lane0_pc, .lane0_dest,
        .lane0_addr, .lane0_wdata, .lane0_result,
        .lane1_valid, .lane1_kind, .lane1_pc, .lane1_dest,
        .lane1_addr, .lane1_wdata, .lane1_result,
        .irq, .status_ie, .unblock,
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_addr_ok,
        .cx (u_commit_if.producer)
    );

    data_stage u_data_stage
    (
        .clk, .reset, .dmem_data_ok, .dmem_rdata,
        .cx (u_commit_if.consumer),
        .unblock,
        .lane0_wb_valid, .lane0_wb_pc, .lane0_wb_dest, .lane0_wb_data,
        .lane1_wb_valid, .lane1_wb_pc, .lane1_wb_dest, .lane1_wb_data,
        .redirect_valid, .redirect_pc, .exc_cause, .exc_epc
    );

endmodule

// ==== verif/commit_unit_tb.sv ====
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_unit_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_BUNDLES = 400;
    localparam int WATCHDOG_NS = (NUM_BUNDLES * 20 + 16) * CLK_PERIOD;
    localparam commit_pkg::word_t ADDR_BASE = 32'h0000_2000;

    // one expected commit event, due is -1 when the latency is not fixed
    typedef struct packed {
        logic [1:0]            wb_valid;
        commit_pkg::word_t     pc0;
        commit_pkg::word_t     pc1;
        commit_pkg::reg_addr_t dest0;
        commit_pkg::reg_addr_t dest1;
        commit_pkg::word_t     data0;
        commit_pkg::word_t     data1;
        logic                  redirect;
        commit_pkg::cause_t    cause;
        commit_pkg::word_t     epc;
        int                    due;
    } result_t;

    typedef struct packed {
        logic              we;
        commit_pkg::word_t addr;
        commit_pkg::word_t wdata;
    } mem_op_t;

    logic                  clk, reset, in_valid, in_ready, irq, status_ie;
    logic                  lane0_valid, lane1_valid;
    commit_pkg::op_kind_t  lane0_kind, lane1_kind;
    commit_pkg::word_t     lane0_pc, lane1_pc, lane0_addr, lane1_addr;
    commit_pkg::word_t     lane0_wdata, lane1_wdata, lane0_result, lane1_result;
    commit_pkg::reg_addr_t lane0_dest, lane1_dest;
    logic                  dmem_req, dmem_we, dmem_addr_ok, dmem_data_ok;
    commit_pkg::word_t     dmem_addr, dmem_wdata, dmem_rdata;
    logic                  lane0_wb_valid, lane1_wb_valid, redirect_valid;
    commit_pkg::word_t     lane0_wb_pc, lane1_wb_pc, lane0_wb_data, lane1_wb_data;
    commit_pkg::reg_addr_t lane0_wb_dest, lane1_wb_dest;
    commit_pkg::word_t     redirect_pc, exc_epc;
    commit_pkg::cause_t    exc_cause;

    integer            seed;
    integer            mem_seed;
    int                cycle = 0;
    int                value_errors = 0;
    int                other_errors = 0;
    logic              took = 1'b0;
    logic              blocked = 1'b0;
    result_t           expq [$];
    mem_op_t           memq [$];
    commit_pkg::word_t mem_model [16];
    commit_pkg::word_t mem_resp [16];

    commit_unit u_commit_unit (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic commit_pkg::word_t fill_word(input int idx);
        commit_pkg::word_t addr;
        addr = ADDR_BASE + 32'(idx * 4);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    task automatic report_value(input string what, input commit_pkg::word_t got,
                                input commit_pkg::word_t want);
        value_errors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // expected result of the bundle being accepted on the coming edge
    task automatic model_accept();
        result_t e;
        mem_op_t op;
        logic    int_taken;
        logic    mem0;
        logic    fault0;
        logic    fault1;
        logic    mem_exec;
        int_taken = irq && status_ie;
        mem0   = lane0_kind == `COMMIT_OP_LOAD || lane0_kind == `COMMIT_OP_STORE;
        fault0 = lane0_valid && (lane0_kind == `COMMIT_OP_SYSCALL ||
                                 (mem0 && lane0_addr[1:0] != 2'd0));
        fault1 = lane1_valid && lane1_kind == `COMMIT_OP_SYSCALL;
        e = '0;
        e.pc0   = lane0_pc;
        e.pc1   = lane1_pc;
        e.dest0 = lane0_dest;
        e.dest1 = lane1_dest;
        e.data0 = lane0_result;
        e.data1 = lane1_result;
        e.redirect = int_taken || fault0 || fault1;
        e.epc      = (!int_taken && !fault0 && fault1) ? lane1_pc : lane0_pc;
        if (int_taken)
            e.cause = `COMMIT_CAUSE_INT;
        else if (fault0 && lane0_kind == `COMMIT_OP_LOAD)
            e.cause = `COMMIT_CAUSE_ADEL;
        else if (fault0 && lane0_kind == `COMMIT_OP_STORE)
            e.cause = `COMMIT_CAUSE_ADES;
        else
            e.cause = `COMMIT_CAUSE_SYS;
        mem_exec = lane0_valid && mem0 && !int_taken && !fault0;
        e.wb_valid[0] = lane0_valid && !int_taken && !fault0 &&
                        (lane0_kind == `COMMIT_OP_ALU || lane0_kind == `COMMIT_OP_LOAD);
        e.wb_valid[1] = lane1_valid && !e.redirect && lane1_kind == `COMMIT_OP_ALU;
        if (mem_exec)
        begin
            op.we    = lane0_kind == `COMMIT_OP_STORE;
            op.addr  = lane0_addr;
            op.wdata = lane0_wdata;
            memq.push_back(op);
            if (op.we)
                mem_model[lane0_addr[5:2]] = lane0_wdata;
            else
                e.data0 = mem_model[lane0_addr[5:2]];
        end
        // nothing ahead of it, so it commits two cycles after the accept
        e.due = (!mem_exec && expq.size() == 0) ? cycle + 2 : -1;
        if (e.wb_valid != 2'b00 || e.redirect)
            expq.push_back(e);
        if (e.redirect)
            blocked = 1'b1;
    endtask

    task automatic check_outputs();
        result_t e;
        if (lane0_wb_valid || lane1_wb_valid || redirect_valid)
        begin
            assert (expq.size() != 0)
            else report_problem("commit output with no bundle expected");
            if (expq.size() != 0)
            begin
                e = expq.pop_front();
                assert ({lane1_wb_valid, lane0_wb_valid} == e.wb_valid)
                else report_value("wb_valid", 32'({lane1_wb_valid, lane0_wb_valid}),
                                  32'(e.wb_valid));
                if (lane0_wb_valid && e.wb_valid[0])
                begin
                    assert (lane0_wb_pc == e.pc0) else report_value("lane0 pc", lane0_wb_pc, e.pc0);
                    assert (lane0_wb_dest == e.dest0)
                    else report_value("lane0 dest", 32'(lane0_wb_dest), 32'(e.dest0));
                    assert (lane0_wb_data == e.data0)
                    else report_value("lane0 data", lane0_wb_data, e.data0);
                end
                if (lane1_wb_valid && e.wb_valid[1])
                begin
                    assert (lane1_wb_pc == e.pc1) else report_value("lane1 pc", lane1_wb_pc, e.pc1);
                    assert (lane1_wb_dest == e.dest1)
                    else report_value("lane1 dest", 32'(lane1_wb_dest), 32'(e.dest1));
                    assert (lane1_wb_data == e.data1)
                    else report_value("lane1 data", lane1_wb_data, e.data1);
                end
                assert (redirect_valid == e.redirect)
                else report_value("redirect_valid", 32'(redirect_valid), 32'(e.redirect));
                if (redirect_valid && e.redirect)
                begin
                    assert (redirect_pc == `COMMIT_EXC_VECTOR)
                    else report_value("redirect_pc", redirect_pc, `COMMIT_EXC_VECTOR);
                    assert (exc_cause == e.cause)
                    else report_value("exc_cause", 32'(exc_cause), 32'(e.cause));
                    assert (exc_epc == e.epc) else report_value("exc_epc", exc_epc, e.epc);
                end
                if (e.due >= 0)
                begin
                    assert (cycle == e.due)
                    else report_value("commit cycle", 32'(cycle), 32'(e.due));
                end
            end
        end
        if (redirect_valid)
            blocked = 1'b0;
    endtask

    // outputs and in_ready are settled by the falling edge
    always @(negedge clk)
    begin
        if (reset)
            took = 1'b0;
        else
        begin
            check_outputs();
            if (blocked)
            begin
                assert (!in_ready)
                else report_problem("in_ready high before the redirect of a faulting bundle");
            end
            took = in_valid && in_ready;
            if (took)
                model_accept();
        end
    end

    task automatic build_bundle();
        logic [31:0] r;
        logic [31:0] p;
        logic [31:0] q;
        r = $random(seed);
        p = $random(seed);
        q = $random(seed);
        lane0_valid = r[2:0] != 3'd0;
        lane1_valid = r[4:3] != 2'd0;
        if (r[8:5] < 4'd6)
            lane0_kind = `COMMIT_OP_ALU;
        else if (r[8:5] < 4'd10)
            lane0_kind = `COMMIT_OP_LOAD;
        else if (r[8:5] < 4'd14)
            lane0_kind = `COMMIT_OP_STORE;
        else
            lane0_kind = `COMMIT_OP_SYSCALL;
        lane1_kind = (r[11:9] == 3'd0) ? `COMMIT_OP_SYSCALL : `COMMIT_OP_ALU;
        irq        = r[15:12] == 4'd0;
        status_ie  = r[16];
        // mostly aligned, inside the small memory window
        lane0_addr = ADDR_BASE + {26'd0, r[20:17], 2'b00};
        if (r[23:21] == 3'd0)
            lane0_addr[1:0] = r[25:24];
        lane1_addr   = $random(seed);
        lane0_pc     = {p[31:2], 2'b00};
        lane1_pc     = {p[31:2], 2'b00} + 32'd4;
        lane0_dest   = q[4:0];
        lane1_dest   = q[9:5];
        lane0_wdata  = $random(seed);
        lane1_wdata  = $random(seed);
        lane0_result = $random(seed);
        lane1_result = $random(seed);
        in_valid     = 1'b1;
    endtask

    initial
    begin : stimulus
        logic [31:0] gap;
        {in_valid, irq, status_ie, lane0_valid, lane1_valid, lane0_kind, lane1_kind} = '0;
        {lane0_pc, lane1_pc, lane0_dest, lane1_dest, lane0_addr, lane1_addr} = '0;
        {lane0_wdata, lane1_wdata, lane0_result, lane1_result} = '0;
        seed  = 35591;
        reset = 1'b1;
        for (int i = 0; i < 16; i++)
            mem_model[i] = fill_word(i);
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (in_ready && !dmem_req && !lane0_wb_valid && !lane1_wb_valid && !redirect_valid)
        else report_problem("outputs not at their reset values after reset");
        @(posedge clk);
        #2;
        for (int n = 0; n < NUM_BUNDLES; n++)
        begin
            build_bundle();
            @(posedge clk);
            #2;
            while (!took)
            begin
                @(posedge clk);
                #2;
            end
            in_valid = 1'b0;
            gap = $random(seed);
            if (gap[2:0] == 3'd0)
            begin
                @(posedge clk);
                #2;
            end
        end
        while (expq.size() != 0 || memq.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // data memory with random addr_ok and data_ok latency
    initial
    begin : memory_responder
        mem_op_t     want;
        mem_op_t     got;
        logic [31:0] r;
        dmem_addr_ok = 1'b0;
        dmem_data_ok = 1'b0;
        dmem_rdata   = '0;
        mem_seed     = 35591;
        for (int i = 0; i < 16; i++)
            mem_resp[i] = fill_word(i);
        @(negedge reset);
        forever
        begin
            @(posedge clk);
            #2;
            if (dmem_req)
            begin
                r = $random(mem_seed);
                got.we    = dmem_we;
                got.addr  = dmem_addr;
                got.wdata = dmem_wdata;
                assert (memq.size() != 0)
                else report_problem("memory request issued with no access expected");
                if (memq.size() != 0)
                begin
                    want = memq.pop_front();
                    assert (got.we == want.we) else report_value("dmem_we", 32'(got.we), 32'(want.we));
                    assert (got.addr == want.addr) else report_value("dmem_addr", got.addr, want.addr);
                    assert (!want.we || got.wdata == want.wdata)
                    else report_value("dmem_wdata", got.wdata, want.wdata);
                end
                repeat (r[1:0])
                begin
                    @(posedge clk);
                    #2;
                end
                dmem_addr_ok = 1'b1;
                @(posedge clk);
                #2;
                dmem_addr_ok = 1'b0;
                if (got.we)
                    mem_resp[got.addr[5:2]] = got.wdata;
                else
                begin
                    repeat (r[3:2])
                    begin
                        @(posedge clk);
                        #2;
                    end
                    dmem_data_ok = 1'b1;
                    dmem_rdata   = mem_resp[got.addr[5:2]];
                    @(posedge clk);
                    #2;
                    dmem_data_ok = 1'b0;
                end
            end
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the commit unit hung with %0d results outstanding", expq.size());
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== commit_unit.f ====
+incdir+hdl
hdl/commit_pkg.sv
hdl/commit_if.sv
hdl/exception_stage.sv
hdl/data_stage.sv
hdl/commit_unit.sv
verif/commit_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the commit unit testbench

VERILATOR ?= verilator
TOP       ?= commit_unit_tb
FILELIST  ?= commit_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "=== PASS ===" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
